// ==== verilog/fetch_pkg.sv ====
package fetch_pkg;

  // processor side word types
  typedef logic [31:0] pc_t;
  typedef logic [15:0] instr_t;
  typedef logic [15:0] half_t;    // counter half, same width as popped stack data

  typedef struct packed {
    half_t hi;
    half_t lo;
  } pc_halves_t;

  // counter word, seen as one address or as two halves for the restore
  typedef union packed {
    pc_t        addr;
    pc_halves_t halves;
  } pc_word_u;

  typedef enum logic [1:0] {
    PC_SEL_NEXT   = 2'd0,
    PC_SEL_BRANCH = 2'd1,
    PC_SEL_HOLD   = 2'd2,
    PC_SEL_BOOT   = 2'd3
  } pc_sel_e;

  localparam pc_t PC_BOOT_VECTOR = 32'h0000_0020;
  localparam pc_t PC_IRQ_VECTOR  = 32'h0000_0000;

  // instruction memory, cut down from the full 20-bit fetch space
  localparam int IMEM_ADDR_W = 12;
  localparam int IMEM_DEPTH  = 4096;

endpackage

// ==== verilog/axil_pkg.sv ====
package axil_pkg;

  typedef logic [31:0] axil_addr_t;
  typedef logic [31:0] axil_data_t;
  typedef logic [1:0]  axil_resp_t;

  localparam axil_resp_t AXIL_OKAY   = 2'b00;
  localparam axil_resp_t AXIL_SLVERR = 2'b10;

  // everything the master drives
  typedef struct packed {
    axil_addr_t awaddr;
    logic       awvalid;
    axil_data_t wdata;
    logic [3:0] wstrb;
    logic       wvalid;
    logic       bready;
    axil_addr_t araddr;
    logic       arvalid;
    logic       rready;
  } axil_req_t;

  // everything the slave drives
  typedef struct packed {
    logic       awready;
    logic       wready;
    axil_resp_t bresp;
    logic       bvalid;
    logic       arready;
    axil_data_t rdata;
    axil_resp_t rresp;
    logic       rvalid;
  } axil_rsp_t;

endpackage

// ==== verilog/pc_unit.sv ====
`timescale 1ns/1ps

module pc_unit (
  input  logic              clk,
  input  logic              reset,
  input  logic              pc_enable,
  input  logic              interrupt,
  input  logic              pop_lo,
  input  logic              pop_hi,
  input  fetch_pkg::pc_sel_e pc_sel,
  input  fetch_pkg::pc_t    branch_addr,
  input  fetch_pkg::half_t  pop_data,
  output fetch_pkg::pc_t    pc
);
  import fetch_pkg::*;

  pc_word_u pc_q;
  pc_word_u pc_d;
  pc_t      pc_inc;
  pc_t      pc_sel_addr;

  assign pc_inc = pc_q.addr + 32'd1;   // one instruction word per step

  always_comb
  begin
    case (pc_sel)
      PC_SEL_NEXT:   pc_sel_addr = pc_inc;
      PC_SEL_BRANCH: pc_sel_addr = branch_addr;   // branch or call target
      PC_SEL_HOLD:   pc_sel_addr = pc_q.addr;
      PC_SEL_BOOT:   pc_sel_addr = PC_BOOT_VECTOR;
      default:       pc_sel_addr = pc_q.addr;
    endcase
  end

  // next counter value, highest priority first
  always_comb
  begin
    pc_d = pc_q;
    if (pop_lo || pop_hi)
    begin
      // return restore ignores pc_enable
      if (pop_lo)
      begin
        pc_d.halves.lo = pop_data;
      end
      if (pop_hi)
      begin
        pc_d.halves.hi = pop_data;
      end
    end
    else if (pc_enable)
    begin
      if (interrupt)
      begin
        pc_d.addr = PC_IRQ_VECTOR;   // overrides any selection
      end
      else
      begin
        pc_d.addr = pc_sel_addr;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      pc_q.addr <= PC_BOOT_VECTOR;
    end
    else
    begin
      pc_q <= pc_d;
    end
  end

  assign pc = pc_q.addr;

endmodule

// ==== verilog/instr_mem.sv ====
`timescale 1ns/1ps

module instr_mem (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             fetch_en,
  input  fetch_pkg::pc_t                   fetch_addr,
  output fetch_pkg::instr_t                instruction,
  input  logic                             host_we,
  input  logic                             host_re,
  input  logic [fetch_pkg::IMEM_ADDR_W-1:0] host_idx,
  input  fetch_pkg::instr_t                host_wdata,
  output fetch_pkg::instr_t                host_rdata
);
  import fetch_pkg::*;

  instr_t                 mem [IMEM_DEPTH];
  logic [IMEM_ADDR_W-1:0] fetch_idx;

  // upper counter bits fall outside the shortened memory
  assign fetch_idx = fetch_addr[IMEM_ADDR_W-1:0];

  // fetch port, register frozen while stalled
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      instruction <= '0;
    end
    else if (fetch_en)
    begin
      instruction <= mem[fetch_idx];   // old data on a same-cycle host write
    end
  end

  // host port
  always_ff @(posedge clk)
  begin
    if (host_we)
    begin
      mem[host_idx] <= host_wdata;
    end
    if (host_re)
    begin
      host_rdata <= mem[host_idx];
    end
  end

endmodule

// ==== verilog/imem_axil_slave.sv ====
`timescale 1ns/1ps

module imem_axil_slave (
  input  logic                             clk,
  input  logic                             reset,
  input  axil_pkg::axil_req_t              axil_req,
  output axil_pkg::axil_rsp_t              axil_rsp,
  output logic                             mem_we,
  output logic                             mem_re,
  output logic [fetch_pkg::IMEM_ADDR_W-1:0] mem_idx,
  output fetch_pkg::instr_t                mem_wdata,
  input  fetch_pkg::instr_t                mem_rdata
);
  import fetch_pkg::*;
  import axil_pkg::*;

  logic [30:0] wr_word;   // byte address of 16-bit words, so drop bit 0
  logic [30:0] rd_word;
  logic        wr_ok;
  logic        rd_ok;
  logic        aw_accept;
  logic        ar_accept;
  logic        bvalid_q;
  axil_resp_t  bresp_q;
  logic        rd_pend;   // memory read in flight
  logic        rd_err;
  logic        rvalid_q;
  axil_data_t  rdata_q;
  axil_resp_t  rresp_q;

  assign wr_word = axil_req.awaddr[31:1];
  assign rd_word = axil_req.araddr[31:1];
  assign wr_ok   = (wr_word < 31'(IMEM_DEPTH));
  assign rd_ok   = (rd_word < 31'(IMEM_DEPTH));

  // one port to memory, so a write wins the cycle
  assign aw_accept = axil_req.awvalid && axil_req.wvalid && !bvalid_q;
  assign ar_accept = axil_req.arvalid && !rd_pend && !rvalid_q && !aw_accept;

  assign mem_we    = aw_accept && wr_ok && (&axil_req.wstrb[1:0]);
  assign mem_re    = ar_accept && rd_ok;
  assign mem_idx   = aw_accept ? wr_word[IMEM_ADDR_W-1:0] : rd_word[IMEM_ADDR_W-1:0];
  assign mem_wdata = axil_req.wdata[15:0];   // upper half of the bus word dropped

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      bvalid_q <= 1'b0;
      rd_pend  <= 1'b0;
      rvalid_q <= 1'b0;
    end
    else
    begin
      if (aw_accept)
      begin
        bvalid_q <= 1'b1;
      end
      else if (axil_req.bready)
      begin
        bvalid_q <= 1'b0;
      end
      rd_pend <= ar_accept;
      if (rd_pend)
      begin
        rvalid_q <= 1'b1;   // memory data is ready now
      end
      else if (axil_req.rready)
      begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // response payload
  always_ff @(posedge clk)
  begin
    if (aw_accept)
    begin
      bresp_q <= wr_ok ? AXIL_OKAY : AXIL_SLVERR;
    end
    if (ar_accept)
    begin
      rd_err <= !rd_ok;
    end
    if (rd_pend)
    begin
      rdata_q <= rd_err ? '0 : {16'h0000, mem_rdata};
      rresp_q <= rd_err ? AXIL_SLVERR : AXIL_OKAY;
    end
  end

  always_comb
  begin
    axil_rsp         = '0;
    axil_rsp.awready = aw_accept;   // both pulse on the accept cycle
    axil_rsp.wready  = aw_accept;
    axil_rsp.bvalid  = bvalid_q;
    axil_rsp.bresp   = bresp_q;
    axil_rsp.arready = ar_accept;
    axil_rsp.rvalid  = rvalid_q;
    axil_rsp.rdata   = rdata_q;
    axil_rsp.rresp   = rresp_q;
  end

endmodule

// ==== verilog/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage (
  input  logic                clk,
  input  logic                reset,
  input  logic                pc_enable,
  input  logic                interrupt,
  input  logic                pop_lo,
  input  logic                pop_hi,
  input  fetch_pkg::pc_sel_e  pc_sel,
  input  fetch_pkg::pc_t      branch_addr,
  input  fetch_pkg::half_t    pop_data,
  input  axil_pkg::axil_req_t axil_req,
  output fetch_pkg::pc_t      pc,
  output fetch_pkg::instr_t   instruction,
  output axil_pkg::axil_rsp_t axil_rsp
);
  import fetch_pkg::*;

  // loader side memory port
  logic                   host_we;
  logic                   host_re;
  logic [IMEM_ADDR_W-1:0] host_idx;
  instr_t                 host_wdata;
  instr_t                 host_rdata;

  pc_unit pc_unit_i (
    .clk         (clk),
    .reset       (reset),
    .pc_enable   (pc_enable),
    .interrupt   (interrupt),
    .pop_lo      (pop_lo),
    .pop_hi      (pop_hi),
    .pc_sel      (pc_sel),
    .branch_addr (branch_addr),
    .pop_data    (pop_data),
    .pc          (pc)
  );

  instr_mem instr_mem_i (
    .clk         (clk),
    .reset       (reset),
    .fetch_en    (pc_enable),   // fetch register follows the stall
    .fetch_addr  (pc),
    .instruction (instruction),
    .host_we     (host_we),
    .host_re     (host_re),
    .host_idx    (host_idx),
    .host_wdata  (host_wdata),
    .host_rdata  (host_rdata)
  );

  imem_axil_slave imem_axil_slave_i (
    .clk       (clk),
    .reset     (reset),
    .axil_req  (axil_req),
    .axil_rsp  (axil_rsp),
    .mem_we    (host_we),
    .mem_re    (host_re),
    .mem_idx   (host_idx),
    .mem_wdata (host_wdata),
    .mem_rdata (host_rdata)
  );

endmodule

// ==== sim/fetch_stage_chk.sv ====
`timescale 1ns/1ps

module fetch_stage_chk (
  input logic                clk,
  input logic                reset,
  input logic                pc_enable,
  input logic                pop_lo,
  input logic                pop_hi,
  input fetch_pkg::pc_t      pc,
  input axil_pkg::axil_req_t axil_req,
  input axil_pkg::axil_rsp_t axil_rsp
);
  import fetch_pkg::*;

  // no enable and no restore means the counter stays put
  pc_hold_a: assert property (@(posedge clk) disable iff (reset)
    (!pc_enable && !pop_lo && !pop_hi) |=> (pc == $past(pc)))
    else $error("pc moved with pc_enable and both pops low");

  bvalid_hold_a: assert property (@(posedge clk) disable iff (reset)
    (axil_rsp.bvalid && !axil_req.bready) |=> axil_rsp.bvalid)
    else $error("bvalid dropped before bready");

  rvalid_hold_a: assert property (@(posedge clk) disable iff (reset)
    (axil_rsp.rvalid && !axil_req.rready) |=> axil_rsp.rvalid)
    else $error("rvalid dropped before rready");

  boot_a: assert property (@(posedge clk) reset |=> (pc == PC_BOOT_VECTOR))
    else $error("pc is not the boot vector after reset");

endmodule

bind fetch_stage fetch_stage_chk chk_i (
  .clk       (clk),
  .reset     (reset),
  .pc_enable (pc_enable),
  .pop_lo    (pop_lo),
  .pop_hi    (pop_hi),
  .pc        (pc),
  .axil_req  (axil_req),
  .axil_rsp  (axil_rsp)
);

// ==== sim/fetch_stage_tb.sv ====
`timescale 1ns/1ps

module fetch_stage_tb;
  import fetch_pkg::*;
  import axil_pkg::*;

  localparam int WAIT_LIMIT = 20;   // cycles per handshake wait

  logic clk;
  logic reset;
  logic pc_enable;
  logic interrupt;
  logic pop_lo;
  logic pop_hi;
  pc_sel_e pc_sel;
  pc_t branch_addr;
  half_t pop_data;
  axil_req_t req;
  axil_rsp_t rsp;
  pc_t pc;
  instr_t instruction;

  // reference state
  pc_t exp_pc;
  instr_t exp_instr;
  bit exp_known;
  instr_t mem_m [IMEM_DEPTH];
  bit known_m [IMEM_DEPTH];   // words the host has written
  logic [31:0] lcg_state = 32'h2c96_8ccf;
  string cur_test = "reset";
  int errors = 0;
  int checks = 0;

  fetch_stage dut_i (
    .clk         (clk),
    .reset       (reset),
    .pc_enable   (pc_enable),
    .interrupt   (interrupt),
    .pop_lo      (pop_lo),
    .pop_hi      (pop_hi),
    .pc_sel      (pc_sel),
    .branch_addr (branch_addr),
    .pop_data    (pop_data),
    .axil_req    (req),
    .pc          (pc),
    .instruction (instruction),
    .axil_rsp    (rsp)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("mismatch %s %s: expected %h actual %h", cur_test, what, exp, act);
    end
  endtask

  // one clock edge of the counter and fetch register rules
  task automatic update_model();
    if (pc_enable)
    begin
      exp_known = known_m[exp_pc[IMEM_ADDR_W-1:0]];   // fetch at the old pc
      exp_instr = mem_m[exp_pc[IMEM_ADDR_W-1:0]];
    end
    if (pop_lo || pop_hi)
    begin
      if (pop_lo)
        exp_pc[15:0] = pop_data;
      if (pop_hi)
        exp_pc[31:16] = pop_data;
    end
    else if (pc_enable && interrupt)
      exp_pc = 32'h0;
    else if (pc_enable)
    begin
      case (pc_sel)
        PC_SEL_NEXT:   exp_pc = exp_pc + 32'd1;
        PC_SEL_BRANCH: exp_pc = branch_addr;
        PC_SEL_BOOT:   exp_pc = 32'h20;
        default:       exp_pc = exp_pc;
      endcase
    end
  endtask

  // edge, then settle, then compare against the model
  task automatic tick();
    @(posedge clk);
    #1;
    update_model();
    check_value("pc", exp_pc, pc);
    if (exp_known)
      check_value("instruction", {16'h0, exp_instr}, {16'h0, instruction});
  endtask

  task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                            input axil_resp_t exp_resp, input int bdelay);
    int t;
    logic done;
    axil_resp_t resp;
    logic [30:0] idx;
    idx = addr[31:1];
    req.awaddr = addr;
    req.wdata = data;
    req.wstrb = 4'hf;
    req.awvalid = 1'b1;
    req.wvalid = 1'b1;
    req.bready = 1'b0;
    t = 0;
    done = 1'b0;
    while (!done && t < WAIT_LIMIT)
    begin
      @(negedge clk);
      done = rsp.awready && rsp.wready;
      tick();
      t++;
    end
    req.awvalid = 1'b0;
    req.wvalid = 1'b0;
    if (!done)
    begin
      errors++;
      $display("%s: write to %h was never accepted", cur_test, addr);
    end
    if (exp_resp == AXIL_OKAY)
    begin
      mem_m[idx[IMEM_ADDR_W-1:0]] = data[15:0];
      known_m[idx[IMEM_ADDR_W-1:0]] = 1'b1;
    end
    for (int i = 0; i < bdelay; i++)
    begin
      check_value("bvalid held", 32'd1, {31'd0, rsp.bvalid});
      tick();
    end
    req.bready = 1'b1;
    t = 0;
    done = 1'b0;
    while (!done && t < WAIT_LIMIT)
    begin
      @(negedge clk);
      done = rsp.bvalid;
      resp = rsp.bresp;
      tick();
      t++;
    end
    req.bready = 1'b0;
    if (!done)
    begin
      errors++;
      $display("%s: no write response for %h", cur_test, addr);
    end
    check_value("bresp", {30'd0, exp_resp}, {30'd0, resp});
  endtask

  task automatic axil_read(input logic [31:0] addr, input logic [31:0] exp_data,
                           input axil_resp_t exp_resp);
    int t;
    logic done;
    logic [31:0] data;
    axil_resp_t resp;
    req.araddr = addr;
    req.arvalid = 1'b1;
    req.rready = 1'b0;
    t = 0;
    done = 1'b0;
    while (!done && t < WAIT_LIMIT)
    begin
      @(negedge clk);
      done = rsp.arready;
      tick();
      t++;
    end
    req.arvalid = 1'b0;
    if (!done)
    begin
      errors++;
      $display("%s: read of %h was never accepted", cur_test, addr);
    end
    t = 0;
    done = 1'b0;
    while (!done && t < WAIT_LIMIT)
    begin
      @(negedge clk);
      done = rsp.rvalid;
      data = rsp.rdata;
      resp = rsp.rresp;
      tick();
      t++;
    end
    if (!done)
    begin
      errors++;
      $display("%s: read of %h got no data", cur_test, addr);
    end
    check_value("rvalid held", 32'd1, {31'd0, rsp.rvalid});   // rready still low
    req.rready = 1'b1;
    tick();
    req.rready = 1'b0;
    check_value("rdata", exp_data, data);
    check_value("rresp", {30'd0, exp_resp}, {30'd0, resp});
  endtask

  task automatic reset_and_stall();
    cur_test = "reset_and_stall";
    check_value("boot pc", 32'h20, pc);
    check_value("reset instruction", 32'h0, {16'h0, instruction});
    pc_enable = 1'b1;
    pc_sel = PC_SEL_NEXT;
    repeat (5) tick();
    pc_enable = 1'b0;
    repeat (3) tick();
  endtask

  task automatic load_and_fetch();
    cur_test = "load_and_fetch";
    for (int i = 32'h20; i < 32'h40; i++)
      axil_write(i * 2, lcg_next(), AXIL_OKAY, 0);
    pc_enable = 1'b1;
    pc_sel = PC_SEL_BRANCH;
    branch_addr = 32'h20;
    tick();
    pc_sel = PC_SEL_NEXT;
    repeat (32) tick();   // instruction trails pc by one edge
    pc_enable = 1'b0;
    repeat (3) tick();   // stalled on the last loaded word
  endtask

  task automatic select_priority();
    cur_test = "select_priority";
    pc_enable = 1'b1;
    branch_addr = lcg_next();
    pc_sel = PC_SEL_BRANCH;
    tick();
    pc_sel = PC_SEL_BOOT;
    tick();
    pc_sel = PC_SEL_HOLD;
    repeat (2) tick();
    interrupt = 1'b1;
    for (int s = 0; s < 4; s++)
    begin
      pc_sel = pc_sel_e'(s);
      tick();
    end
    interrupt = 1'b0;
    pc_sel = PC_SEL_BRANCH;
    tick();
    pc_enable = 1'b0;
    interrupt = 1'b1;   // stalled, so no vector
    repeat (2) tick();
    interrupt = 1'b0;
  endtask

  task automatic stack_restore();
    pc_t target;
    cur_test = "stack_restore";
    target = lcg_next();
    pop_lo = 1'b1;
    pop_data = target[15:0];
    tick();
    pop_lo = 1'b0;
    pop_hi = 1'b1;
    pop_data = target[31:16];
    pc_enable = 1'b1;
    pc_sel = PC_SEL_BOOT;
    tick();
    check_value("restored pc", target, pc);
    pop_lo = 1'b1;
    pop_data = lcg_state[15:0];
    tick();
    pop_lo = 1'b0;
    pop_hi = 1'b0;
    pc_enable = 1'b0;
  endtask

  task automatic bus_read_errors();
    cur_test = "bus_read_errors";
    axil_read(32'h40, {16'h0, mem_m[12'h20]}, AXIL_OKAY);
    axil_read(32'h4e, {16'h0, mem_m[12'h27]}, AXIL_OKAY);
    axil_read(32'h7e, {16'h0, mem_m[12'h3f]}, AXIL_OKAY);
    axil_write(32'h0, 32'h0000_a5c3, AXIL_OKAY, 0);
    axil_write(32'h2000, 32'h0000_1234, AXIL_SLVERR, 0);   // would alias word 0
    axil_read(32'h0, {16'h0, mem_m[12'h0]}, AXIL_OKAY);
    axil_read(32'h2000, 32'h0, AXIL_SLVERR);
    axil_write(32'h42, lcg_next(), AXIL_OKAY, 5);
    axil_read(32'h42, {16'h0, mem_m[12'h21]}, AXIL_OKAY);
  endtask

  task automatic random_mix();
    logic [31:0] r;
    cur_test = "random_mix";
    for (int n = 0; n < 200; n++)
    begin
      r = lcg_next();
      pc_enable = r[0] | r[1];
      pc_sel = pc_sel_e'(r[3:2]);
      interrupt = (r[7:4] == 4'd0);
      pop_lo = (r[11:8] == 4'd0);
      pop_hi = (r[15:12] == 4'd0);
      pop_data = r[31:16];
      branch_addr = 32'h20 | {27'd0, r[20:16]};   // back into loaded words
      tick();
    end
    pc_enable = 1'b0;
    interrupt = 1'b0;
    pop_lo = 1'b0;
    pop_hi = 1'b0;
  endtask

  initial
  begin
    reset = 1'b1;
    pc_enable = 1'b0;
    interrupt = 1'b0;
    pop_lo = 1'b0;
    pop_hi = 1'b0;
    pc_sel = PC_SEL_NEXT;
    branch_addr = 32'h0;
    pop_data = 16'h0;
    req = '0;
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
    exp_pc = 32'h20;
    exp_instr = 16'h0;
    exp_known = 1'b1;
    reset_and_stall();
    load_and_fetch();
    select_priority();
    stack_restore();
    bus_read_errors();
    random_mix();
    $display("errors: %0d in %0d checks", errors, checks);
    if (errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== build.f ====
verilog/fetch_pkg.sv
verilog/axil_pkg.sv
verilog/pc_unit.sv
verilog/instr_mem.sv
verilog/imem_axil_slave.sv
verilog/fetch_stage.sv
sim/fetch_stage_chk.sv
sim/fetch_stage_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the fetch stage testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f build.f --top-module fetch_stage_tb \
  -o fetch_stage_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/fetch_stage_sim > sim.log 2>&1 || { cat sim.log; echo "simulation aborted"; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST PASSED" sim.log || { echo "no result in log"; exit 1; }
exit 0
